// ==== verilog/mips_pkg.sv ====
package mips_pkg;

    ////////////////////////////////////////
    // Widths and sizes
    ////////////////////////////////////////

    localparam int DATA_WIDTH      = 32;
    localparam int REG_ADDR_WIDTH  = 5;
    localparam int NUM_REGS        = 32;
    localparam int DMEM_DEPTH      = 256;
    localparam int DMEM_ADDR_WIDTH = 8;

    typedef logic [DATA_WIDTH-1:0]     word_t;
    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

    localparam word_t RESET_PC = '0;
    localparam word_t PC_STEP  = 32'd4;

    ////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////

    // Primary opcode, instr[31:26]
    typedef enum logic [5:0] {
        OP_R_TYPE = 6'h00,
        OP_BEQ    = 6'h04,
        OP_ADDIU  = 6'h09,
        OP_LW     = 6'h23,
        OP_SW     = 6'h2b
    } opcode_e;

    // R-type function field, instr[5:0]
    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_FROM_ID,
        FWD_FROM_MEM,
        FWD_FROM_WB
    } fwd_sel_e;

    ////////////////////////////////////////
    // Pipeline payloads
    ////////////////////////////////////////

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    branch;
        logic    use_imm;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        logic      valid;
        ctrl_t     ctrl;
        word_t     pc_plus4;
        word_t     rs_data;
        word_t     rt_data;
        word_t     imm;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        word_t     result;
        word_t     store_data;
        reg_addr_t rd;
    } ex_mem_t;

    typedef struct packed {
        logic      valid;
        logic      reg_write;
        word_t     wb_data;
        reg_addr_t rd;
    } mem_wb_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     data;
    } commit_t;

endpackage

// ==== verilog/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder
    import mips_pkg::*;
(
    input  word_t     instr,
    output ctrl_t     ctrl,
    output reg_addr_t rs,
    output reg_addr_t rt,
    output reg_addr_t rd,
    output word_t     imm
);

    opcode_e   opcode;
    funct_e    funct;
    reg_addr_t rd_field;

    // Fixed MIPS field positions
    assign opcode   = opcode_e'(instr[31:26]);
    assign funct    = funct_e'(instr[5:0]);
    assign rs       = instr[25:21];
    assign rt       = instr[20:16];
    assign rd_field = instr[15:11];

    // Sign extension of the 16-bit immediate
    assign imm = {{(DATA_WIDTH-16){instr[15]}}, instr[15:0]};

    always_comb begin
        // Unknown encodings fall through as a harmless no-op
        ctrl = '{
            reg_write: 1'b0,
            mem_read:  1'b0,
            mem_write: 1'b0,
            branch:    1'b0,
            use_imm:   1'b0,
            alu_op:    ALU_ADD
        };
        rd = '0;

        case (opcode)
            OP_R_TYPE: begin
                rd = rd_field;
                ctrl.reg_write = 1'b1;
                case (funct)
                    FN_ADDU: ctrl.alu_op = ALU_ADD;
                    FN_SUBU: ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    default: ctrl.reg_write = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                rd = rt;
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = 1'b1;
            end
            OP_LW: begin
                rd = rt;
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.use_imm   = 1'b1;
            end
            OP_SW: begin
                // Address from rs + imm, store data from rt
                ctrl.mem_write = 1'b1;
                ctrl.use_imm   = 1'b1;
            end
            OP_BEQ: begin
                // Equality compared in execute, ALU result unused
                ctrl.branch = 1'b1;
                ctrl.alu_op = ALU_SUB;
            end
            default: begin
                ctrl.reg_write = 1'b0;
            end
        endcase
    end

endmodule

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ps

module reg_file
    import mips_pkg::*;
(
    input  logic      ui_clk_from_ddr,
    input  logic      rst_n,
    input  reg_addr_t rs,
    input  reg_addr_t rt,
    output word_t     rs_data,
    output word_t     rt_data,
    input  logic      wr_en,
    input  reg_addr_t wr_addr,
    input  word_t     wr_data
);

    word_t regs [NUM_REGS];

    always_ff @(posedge ui_clk_from_ddr) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Writeback result seen by decode in the same cycle
    assign rs_data = (rs == '0) ? '0 :
                     (wr_en && wr_addr == rs) ? wr_data : regs[rs];
    assign rt_data = (rt == '0) ? '0 :
                     (wr_en && wr_addr == rt) ? wr_data : regs[rt];

endmodule

// ==== verilog/hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit
    import mips_pkg::*;
(
    input  reg_addr_t id_rs,
    input  reg_addr_t id_rt,
    input  logic      ex_mem_read,
    input  reg_addr_t ex_rd,
    output logic      stall
);

    logic ex_load_live;
    logic rs_match;
    logic rt_match;

    ////////////////////////////////////////
    // Load-use interlock
    ////////////////////////////////////////

    // A load to r0 produces nothing worth waiting for
    assign ex_load_live = ex_mem_read && (ex_rd != '0);

    // rt is compared even for I-type, a spare bubble is harmless
    assign rs_match = (ex_rd == id_rs);
    assign rt_match = (ex_rd == id_rt);

    // One bubble is enough, the load reaches WB when the consumer is in EX
    assign stall = ex_load_live && (rs_match || rt_match);

endmodule

// ==== verilog/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage
    import mips_pkg::*;
(
    input  id_ex_t  id_ex,
    input  ex_mem_t mem_fwd,
    input  mem_wb_t wb_fwd,
    output ex_mem_t ex_mem,
    output logic    branch_taken,
    output word_t   branch_target
);

    fwd_sel_e rs_sel;
    fwd_sel_e rt_sel;
    word_t    op_a;
    word_t    op_b_reg;
    word_t    op_b;
    word_t    alu_out;

    ////////////////////////////////////////
    // Forwarding
    ////////////////////////////////////////

    // MEM holds the younger producer, so it is checked first
    function automatic fwd_sel_e pick_source(input reg_addr_t src);
        if (mem_fwd.valid && mem_fwd.reg_write && mem_fwd.rd != '0 && mem_fwd.rd == src) begin
            return FWD_FROM_MEM;
        end
        if (wb_fwd.valid && wb_fwd.reg_write && wb_fwd.rd != '0 && wb_fwd.rd == src) begin
            return FWD_FROM_WB;
        end
        return FWD_FROM_ID;
    endfunction

    function automatic word_t fwd_mux(input fwd_sel_e sel, input word_t id_value);
        case (sel)
            FWD_FROM_MEM: return mem_fwd.result;
            FWD_FROM_WB:  return wb_fwd.wb_data;
            default:      return id_value;
        endcase
    endfunction

    assign rs_sel   = pick_source(id_ex.rs);
    assign rt_sel   = pick_source(id_ex.rt);
    assign op_a     = fwd_mux(rs_sel, id_ex.rs_data);
    assign op_b_reg = fwd_mux(rt_sel, id_ex.rt_data);
    assign op_b     = id_ex.ctrl.use_imm ? id_ex.imm : op_b_reg;

    ////////////////////////////////////////
    // ALU
    ////////////////////////////////////////

    always_comb begin
        case (id_ex.ctrl.alu_op)
            ALU_ADD: alu_out = op_a + op_b;
            ALU_SUB: alu_out = op_a - op_b;
            ALU_AND: alu_out = op_a & op_b;
            ALU_OR:  alu_out = op_a | op_b;
            ALU_SLT: alu_out = {{(DATA_WIDTH-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            default: alu_out = '0;
        endcase
    end

    // BEQ compares the forwarded register values
    assign branch_taken  = id_ex.valid && id_ex.ctrl.branch && (op_a == op_b_reg);
    assign branch_target = id_ex.pc_plus4 + {id_ex.imm[DATA_WIDTH-3:0], 2'b00};

    // Control bits go out already qualified by valid
    always_comb begin
        ex_mem.valid      = id_ex.valid;
        ex_mem.reg_write  = id_ex.valid && id_ex.ctrl.reg_write;
        ex_mem.mem_read   = id_ex.valid && id_ex.ctrl.mem_read;
        ex_mem.mem_write  = id_ex.valid && id_ex.ctrl.mem_write;
        ex_mem.result     = alu_out;
        ex_mem.store_data = op_b_reg;
        ex_mem.rd         = id_ex.rd;
    end

endmodule

// ==== verilog/data_mem.sv ====
`timescale 1ns/1ps

module data_mem
    import mips_pkg::*;
(
    input  logic                       ui_clk_from_ddr,
    input  logic [DMEM_ADDR_WIDTH-1:0] addr,
    input  logic                       wr_en,
    input  word_t                      wr_data,
    output word_t                      rd_data
);

    word_t ram [DMEM_DEPTH];

    // Word writes only
    always_ff @(posedge ui_clk_from_ddr) begin
        if (wr_en) begin
            ram[addr] <= wr_data;
        end
    end

    // Asynchronous read, load data ready within the MEM cycle
    assign rd_data = ram[addr];

endmodule

// ==== verilog/mips_core.sv ====
`timescale 1ns/1ps

module mips_core
    import mips_pkg::*;
(
    input  logic    ui_clk_from_ddr,
    input  logic    rst_n,
    input  word_t   instr,
    output word_t   pc,
    output commit_t commit
);

    // IF/ID
    logic      if_id_valid;
    word_t     if_id_instr;
    word_t     if_id_pc_plus4;
    word_t     if_pc_plus4;

    // Decode outputs
    ctrl_t     id_ctrl;
    reg_addr_t id_rs;
    reg_addr_t id_rt;
    reg_addr_t id_rd;
    word_t     id_imm;
    word_t     id_rs_data;
    word_t     id_rt_data;

    id_ex_t    id_ex_next;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem_next;
    ex_mem_t   ex_mem;
    mem_wb_t   mem_wb_next;
    mem_wb_t   mem_wb;

    logic      stall;
    logic      branch_taken;
    word_t     branch_target;
    word_t     dmem_rd_data;

    ////////////////////////////////////////
    // Fetch
    ////////////////////////////////////////

    assign if_pc_plus4 = pc + PC_STEP;

    always_ff @(posedge ui_clk_from_ddr) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else if (branch_taken) begin
            pc <= branch_target;
        end else if (!stall) begin
            pc <= if_pc_plus4;
        end
    end

    // Taken branch squashes the slot, stall holds it
    always_ff @(posedge ui_clk_from_ddr) begin
        if (!rst_n) begin
            if_id_valid <= 1'b0;
        end else if (branch_taken) begin
            if_id_valid <= 1'b0;
        end else if (!stall) begin
            if_id_valid    <= 1'b1;
            if_id_instr    <= instr;
            if_id_pc_plus4 <= if_pc_plus4;
        end
    end

    ////////////////////////////////////////
    // Decode
    ////////////////////////////////////////

    instr_decoder instr_decoder_i (
        .instr ( if_id_instr ),
        .ctrl  ( id_ctrl     ),
        .rs    ( id_rs       ),
        .rt    ( id_rt       ),
        .rd    ( id_rd       ),
        .imm   ( id_imm      )
    );

    reg_file reg_file_i (
        .ui_clk_from_ddr ( ui_clk_from_ddr                   ),
        .rst_n           ( rst_n                             ),
        .rs              ( id_rs                             ),
        .rt              ( id_rt                             ),
        .rs_data         ( id_rs_data                        ),
        .rt_data         ( id_rt_data                        ),
        .wr_en           ( mem_wb.valid && mem_wb.reg_write  ),
        .wr_addr         ( mem_wb.rd                         ),
        .wr_data         ( mem_wb.wb_data                    )
    );

    hazard_unit hazard_unit_i (
        .id_rs       ( id_rs                              ),
        .id_rt       ( id_rt                              ),
        .ex_mem_read ( id_ex.valid && id_ex.ctrl.mem_read ),
        .ex_rd       ( id_ex.rd                           ),
        .stall       ( stall                              )
    );

    // Bubble on stall or flush
    always_comb begin
        id_ex_next.valid    = if_id_valid && !stall && !branch_taken;
        id_ex_next.ctrl     = id_ctrl;
        id_ex_next.pc_plus4 = if_id_pc_plus4;
        id_ex_next.rs_data  = id_rs_data;
        id_ex_next.rt_data  = id_rt_data;
        id_ex_next.imm      = id_imm;
        id_ex_next.rs       = id_rs;
        id_ex_next.rt       = id_rt;
        id_ex_next.rd       = id_rd;
    end

    ////////////////////////////////////////
    // Execute, memory, writeback
    ////////////////////////////////////////

    execute_stage execute_stage_i (
        .id_ex         ( id_ex         ),
        .mem_fwd       ( ex_mem        ),
        .wb_fwd        ( mem_wb        ),
        .ex_mem        ( ex_mem_next   ),
        .branch_taken  ( branch_taken  ),
        .branch_target ( branch_target )
    );

    data_mem data_mem_i (
        .ui_clk_from_ddr ( ui_clk_from_ddr                      ),
        .addr            ( ex_mem.result[DMEM_ADDR_WIDTH+1:2]   ),
        .wr_en           ( ex_mem.valid && ex_mem.mem_write     ),
        .wr_data         ( ex_mem.store_data                    ),
        .rd_data         ( dmem_rd_data                         )
    );

    // MEM-stage result select
    always_comb begin
        mem_wb_next.valid     = ex_mem.valid;
        mem_wb_next.reg_write = ex_mem.reg_write;
        mem_wb_next.wb_data   = ex_mem.mem_read ? dmem_rd_data : ex_mem.result;
        mem_wb_next.rd        = ex_mem.rd;
    end

    // Only the valid bits carry reset
    always_ff @(posedge ui_clk_from_ddr) begin
        if (!rst_n) begin
            id_ex.valid  <= 1'b0;
            ex_mem.valid <= 1'b0;
            mem_wb.valid <= 1'b0;
        end else begin
            id_ex  <= id_ex_next;
            ex_mem <= ex_mem_next;
            mem_wb <= mem_wb_next;
        end
    end

    // Retired register writes, r0 never reported
    always_comb begin
        commit.valid = mem_wb.valid && mem_wb.reg_write && (mem_wb.rd != '0);
        commit.rd    = mem_wb.rd;
        commit.data  = mem_wb.wb_data;
    end

endmodule

// ==== tb/mips_core_assert.sv ====
`timescale 1ns/1ps

module mips_core_assert
    import mips_pkg::*;
(
    input logic    ui_clk_from_ddr,
    input logic    rst_n,
    input commit_t commit,
    input logic    stall,
    input logic    branch_taken
);

    // Failed property count, read by the testbench at the end of the run
    int failures = 0;

    ////////////////////////////////////////
    // Pipeline properties
    ////////////////////////////////////////

    // First reset edge clears MEM/WB, so commit is quiet from then on
    property commit_quiet_in_reset;
        @(posedge ui_clk_from_ddr) !rst_n |=> !commit.valid;
    endproperty

    property commit_rd_nonzero;
        @(posedge ui_clk_from_ddr) disable iff (!rst_n)
            commit.valid |-> (commit.rd != '0);
    endproperty

    // The bubble removes the load from EX, so the stall drops
    property stall_single_cycle;
        @(posedge ui_clk_from_ddr) disable iff (!rst_n)
            stall |=> !stall;
    endproperty

    property no_flush_during_stall;
        @(posedge ui_clk_from_ddr) disable iff (!rst_n)
            !(stall && branch_taken);
    endproperty

    commit_quiet_in_reset_a: assert property (commit_quiet_in_reset)
        else begin
            failures++;
            $error("commit valid seen while in reset");
        end
    commit_rd_nonzero_a: assert property (commit_rd_nonzero)
        else begin
            failures++;
            $error("commit valid with destination r0");
        end
    stall_single_cycle_a: assert property (stall_single_cycle)
        else begin
            failures++;
            $error("load-use stall held for two cycles");
        end
    no_flush_during_stall_a: assert property (no_flush_during_stall)
        else begin
            failures++;
            $error("branch flush while stall is high");
        end

endmodule

bind mips_core mips_core_assert mips_core_assert_i (
    .ui_clk_from_ddr ( ui_clk_from_ddr ),
    .rst_n           ( rst_n           ),
    .commit          ( commit          ),
    .stall           ( stall           ),
    .branch_taken    ( branch_taken    )
);

// ==== tb/tb_mips_core.sv ====
`timescale 1ns/1ps

module tb_mips_core
    import mips_pkg::*;
();

    localparam int IMEM_WORDS = 64;
    localparam funct_e ALU_FNS [5] = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_SLT};

    logic        ui_clk_from_ddr = 1'b0;
    logic        rst_n;
    word_t       instr;
    word_t       pc;
    commit_t     commit;

    word_t       imem [IMEM_WORDS];
    word_t       prog [$];
    int          prog_len;
    commit_t     expected [$];
    word_t       gold_mem [int];
    logic [31:0] rng_state = 32'd68;
    int          cycle_count = 0;
    int          cycle_limit = 100;
    int          fail_count = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    mips_core mips_core_i (
        .ui_clk_from_ddr ( ui_clk_from_ddr ),
        .rst_n           ( rst_n           ),
        .instr           ( instr           ),
        .pc              ( pc              ),
        .commit          ( commit          )
    );

    always #20 ui_clk_from_ddr = ~ui_clk_from_ddr;

    ////////////////////////////////////////
    // Encoding and random helpers
    ////////////////////////////////////////

    function automatic word_t enc_r(funct_e fn, int rd, int rs, int rt);
        return {OP_R_TYPE, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
    endfunction

    function automatic word_t enc_i(opcode_e op, int rt, int rs, int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic logic [31:0] next_random();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    ////////////////////////////////////////
    // Golden ISA model
    ////////////////////////////////////////

    // Sequential execution with one commit per nonzero register write
    task automatic run_golden();
        word_t   regs [NUM_REGS];
        word_t   w;
        word_t   a;
        word_t   b;
        word_t   imm;
        word_t   addr;
        word_t   res;
        int      gpc;
        int      dest;
        logic    wr;
        commit_t c;
        for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] = '0;
        end
        expected.delete();
        gpc = 0;
        while (gpc < prog_len) begin
            w    = imem[gpc];
            a    = regs[w[25:21]];
            b    = regs[w[20:16]];
            imm  = {{16{w[15]}}, w[15:0]};
            addr = a + imm;
            wr   = 1'b0;
            dest = 0;
            res  = '0;
            gpc++;
            case (w[31:26])
                OP_R_TYPE: begin
                    dest = int'(w[15:11]);
                    wr   = 1'b1;
                    case (w[5:0])
                        FN_ADDU: res = a + b;
                        FN_SUBU: res = a - b;
                        FN_AND:  res = a & b;
                        FN_OR:   res = a | b;
                        FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: wr = 1'b0;
                    endcase
                end
                OP_ADDIU: begin
                    dest = int'(w[20:16]);
                    wr   = 1'b1;
                    res  = addr;
                end
                OP_LW: begin
                    dest = int'(w[20:16]);
                    wr   = 1'b1;
                    res  = gold_mem[int'(addr[9:2])];
                end
                OP_SW: gold_mem[int'(addr[9:2])] = b;
                OP_BEQ: begin
                    // Word offset relative to the following instruction
                    if (a == b) gpc += int'($signed(imm));
                end
                default: wr = 1'b0;
            endcase
            if (wr && dest != 0) begin
                regs[dest] = res;
                c.valid = 1'b1;
                c.rd    = dest[4:0];
                c.data  = res;
                expected.push_back(c);
            end
        end
    endtask

    ////////////////////////////////////////
    // Instruction port and commit checks
    ////////////////////////////////////////

    always @(negedge ui_clk_from_ddr) begin
        commit_t exp;
        if (!rst_n) begin
            assert (pc == RESET_PC) else begin
                $display("[FAIL] %0t pc got %h expected %h", $time, pc, RESET_PC);
                fail_count++;
            end
            assert (!commit.valid) else begin
                $display("[FAIL] %0t commit.valid got %b expected 0",
                         $time, commit.valid);
                fail_count++;
            end
        end else if (commit.valid) begin
            assert (expected.size() != 0) else begin
                $display("Unexpected commit to r%0d at %0t", commit.rd, $time);
                fail_count++;
            end
            if (expected.size() != 0) begin
                exp = expected.pop_front();
                assert (commit.rd == exp.rd) else begin
                    $display("[FAIL] %0t commit.rd got %0d expected %0d",
                             $time, commit.rd, exp.rd);
                    fail_count++;
                end
                assert (commit.data == exp.data) else begin
                    $display("[FAIL] %0t commit.data got %h expected %h",
                             $time, commit.data, exp.data);
                    fail_count++;
                end
            end
        end
        instr <= imem[pc[7:2]];
    end

    always @(posedge ui_clk_from_ddr) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout after %0d cycles, pipeline never drained", cycle_count);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Test sequencing
    ////////////////////////////////////////

    task automatic run_test(input string name);
        int start_fails;
        start_fails = fail_count;
        @(negedge ui_clk_from_ddr);
        rst_n <= 1'b0;
        @(negedge ui_clk_from_ddr);
        prog_len = prog.size();
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = (i < prog_len) ? prog[i] : '0;
        end
        cycle_limit += 3 * prog_len;
        run_golden();
        repeat (2) @(negedge ui_clk_from_ddr);
        rst_n <= 1'b1;
        // Four fetches past the end means the last real instruction has left WB
        do @(negedge ui_clk_from_ddr);
        while (pc < word_t'((prog_len + 4) * 4));
        assert (expected.size() == 0) else begin
            $display("Test %s ended with %0d commits missing", name, expected.size());
            fail_count++;
        end
        tests_run++;
        if (fail_count != start_fails) tests_failed++;
        $display("Test %s: %0d errors", name, fail_count - start_fails);
        prog.delete();
    endtask

    initial begin
        logic [31:0] r;
        rst_n = 1'b0;
        instr = '0;

        // NOPs only so nothing may commit
        repeat (4) prog.push_back('0);
        run_test("reset_idle");

        for (int i = 0; i < 24; i++) begin
            r = next_random();
            if (r[0]) begin
                prog.push_back(enc_i(OP_ADDIU, int'(r[10:8]), int'(r[13:11]),
                                     int'(r[31:16])));
            end else begin
                prog.push_back(enc_r(ALU_FNS[int'(r[3:1]) % 5], int'(r[10:8]),
                                     int'(r[13:11]), int'(r[16:14])));
            end
        end
        run_test("random_alu");

        prog.push_back(enc_i(OP_ADDIU, 1, 0, 5));
        prog.push_back(enc_r(FN_ADDU, 2, 1, 1));
        prog.push_back(enc_r(FN_SUBU, 3, 2, 1));
        prog.push_back(enc_r(FN_OR, 4, 3, 2));
        prog.push_back(enc_r(FN_SLT, 5, 3, 2));
        prog.push_back(enc_r(FN_AND, 6, 4, 5));
        prog.push_back(enc_i(OP_ADDIU, 7, 0, -3));
        prog.push_back(enc_r(FN_SLT, 8, 7, 1));
        run_test("forwarding");

        prog.push_back(enc_i(OP_ADDIU, 1, 0, 'h40));
        prog.push_back(enc_i(OP_ADDIU, 2, 0, 'h1234));
        prog.push_back(enc_i(OP_SW, 2, 1, 0));
        prog.push_back(enc_i(OP_LW, 3, 1, 0));
        prog.push_back(enc_r(FN_ADDU, 4, 3, 3));
        prog.push_back(enc_i(OP_SW, 4, 1, 4));
        prog.push_back(enc_i(OP_LW, 5, 1, 4));
        prog.push_back(enc_i(OP_LW, 6, 1, 0));
        prog.push_back(enc_r(FN_ADDU, 7, 5, 6));
        prog.push_back(enc_i(OP_SW, 7, 1, -8));
        prog.push_back(enc_i(OP_LW, 8, 1, -8));
        prog.push_back(enc_r(FN_SUBU, 9, 8, 2));
        run_test("load_store");

        prog.push_back(enc_i(OP_ADDIU, 1, 0, 3));
        prog.push_back(enc_i(OP_ADDIU, 2, 0, 3));
        prog.push_back(enc_i(OP_BEQ, 2, 1, 2));
        prog.push_back(enc_i(OP_ADDIU, 3, 0, 1));
        prog.push_back(enc_i(OP_ADDIU, 4, 0, 2));
        prog.push_back(enc_i(OP_ADDIU, 5, 0, 7));
        prog.push_back(enc_i(OP_BEQ, 5, 1, 2));
        prog.push_back(enc_i(OP_ADDIU, 6, 0, 8));
        prog.push_back(enc_i(OP_ADDIU, 7, 0, 9));
        // Target lands on the second squashed slot
        prog.push_back(enc_i(OP_BEQ, 0, 0, 1));
        prog.push_back(enc_i(OP_ADDIU, 3, 0, 11));
        prog.push_back(enc_i(OP_ADDIU, 4, 0, 12));
        run_test("branch");

        $display("Summary: %0d tests, %0d failed, %0d errors, %0d assertion failures",
                 tests_run, tests_failed, fail_count,
                 mips_core_i.mips_core_assert_i.failures);
        if (fail_count == 0 && mips_core_i.mips_core_assert_i.failures == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
verilog/mips_pkg.sv
verilog/instr_decoder.sv
verilog/reg_file.sv
verilog/hazard_unit.sv
verilog/execute_stage.sv
verilog/data_mem.sv
verilog/mips_core.sv
tb/mips_core_assert.sv
tb/tb_mips_core.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_mips_core
FILELIST  := verilog.f

OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(wildcard verilog/*.sv tb/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
